// File: Makefile
# Verilator build and run of the afu_core testbench

TOP = afu_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and logs"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f afu_core.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: afu_core.f
+incdir+verilog
verilog/host_pkg.sv
verilog/batch_pkg.sv
verilog/host_request_queue.sv
verilog/response_pairer.sv
verilog/batch_controller.sv
verilog/afu_core.sv
bench/afu_core_tb.sv

// File: bench/afu_core_tb.sv
`timescale 1ns/100ps
`include "afu_params.svh"

module afu_core_tb;

	localparam int n_rows = 4;

	typedef struct packed {
		int   batch_size;
		int   polls;
		int   lookups;
		int   results;
		logic af_en;
	} row_t;

	// batch size, polls before the flag, lookups, results, almost-full pulses
	row_t table_rows [n_rows] = '{
		'{1, 0, 3, 2, 1'b0},
		'{2, 2, 5, 4, 1'b0},
		'{3, 1, 8, 3, 1'b1},
		'{2, 3, 6, 5, 1'b1}
	};

	logic                    CLK_200M;
	logic                    reset_n;
	logic                    core_start;
	host_pkg::host_ptr_t     src_ptr    = 64'h8000;
	host_pkg::host_ptr_t     dst_ptr    = 64'h2_0000;
	host_pkg::host_ptr_t     hand_ptr   = 64'h100;
	host_pkg::host_ptr_t     input_base = 64'h1000;
	logic                    rd_almostfull = 1'b0;
	logic                    wr_almostfull = 1'b0;
	logic                    rx_rd_valid = 1'b0;
	host_pkg::cl_data_t      rx_data = '0;
	logic                    read_load_done = 1'b0;
	logic                    lookup_valid = 1'b0;
	batch_pkg::engine_addr_t lookup_k = '0;
	batch_pkg::engine_addr_t lookup_l = '0;
	logic                    output_request = 1'b0;
	logic                    result_valid = 1'b0;
	host_pkg::cl_data_t      result_data = '0;
	logic                    result_finish = 1'b0;

	logic                    tx_rd_valid;
	host_pkg::cl_addr_t      tx_rd_addr;
	logic                    tx_wr_valid;
	host_pkg::cl_addr_t      tx_wr_addr;
	host_pkg::cl_data_t      tx_data;
	logic                    tx_fence_valid;
	logic                    engine_stall;
	logic                    batch_active;
	logic                    load_valid;
	host_pkg::cl_data_t      load_data;
	logic                    lookup_ready;
	host_pkg::cl_data_t      lookup_line_k;
	host_pkg::cl_data_t      lookup_line_l;
	logic                    output_permit;

	int value_errors = 0;
	int other_errors = 0;
	int row = 0;
	int limit = 100000;
	int cycles = 0;

	afu_core dut_i (.*);

	// ------------------------------------------------------------------------
	// reference functions
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// host memory contents depend on every address bit
	function automatic host_pkg::cl_data_t mem_line(input host_pkg::cl_addr_t addr);
		logic [31:0] a;
		logic [31:0] w;
		host_pkg::cl_data_t line;
		a = addr[31:0] ^ {6'h0, addr[57:32]};
		for (int j = 0; j < 16; j++) begin
			w = (a + j * 32'h0101_0101) * 32'h9e37_79b1;
			line[j*32 +: 32] = w ^ (w >> 15);
		end
		return line;
	endfunction

	function automatic host_pkg::cl_data_t result_line(input int r, input int i);
		return mem_line(58'h4_0000 + 58'(r * 64 + i));
	endfunction

	function automatic batch_pkg::engine_addr_t lookup_k_of(input int r, input int j);
		return 32'(((r * 40 + j * 3) << 4) | j);
	endfunction

	function automatic batch_pkg::engine_addr_t lookup_l_of(input int r, input int j);
		return 32'(((r * 40 + j * 5 + 17) << 4) | (j ^ 7));
	endfunction

	function automatic int safe_row(input int r);
		return (r < n_rows) ? r : n_rows - 1;
	endfunction

	task automatic report_mismatch(input string name, input host_pkg::cl_data_t got,
		input host_pkg::cl_data_t exp);
		$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		value_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("at %0t ns: %s", $time, msg);
		other_errors++;
	endtask

	initial begin
		CLK_200M = 1'b0;
		forever #20 CLK_200M = ~CLK_200M;
	end

	// ------------------------------------------------------------------------
	// host memory model and read order check
	// ------------------------------------------------------------------------
	logic [31:0]        rng = 32'hf056_a035;
	int                 due_q [$];
	host_pkg::cl_data_t data_q [$];
	host_pkg::cl_addr_t exp_rd [$];
	int                 hand_reads;
	logic               load_started;
	int                 last_due;
	int                 due;
	int                 rr;
	host_pkg::cl_data_t hs_line;
	logic               af_seen = 1'b0;

	always @(posedge CLK_200M) begin
		cycles++;
		rng = xorshift(rng);
		rr = safe_row(row);
		// almost-full seen last edge must show up as a stall now
		if (af_seen && engine_stall !== 1'b1)
			report_mismatch("engine_stall", engine_stall, 1);
		af_seen = reset_n && (rd_almostfull || wr_almostfull);
		rd_almostfull <= table_rows[rr].af_en && (rng[7:6] == 2'b00);
		wr_almostfull <= table_rows[rr].af_en && (rng[9:8] == 2'b00);
		if (due_q.size() > 0 && due_q[0] <= cycles) begin
			rx_rd_valid <= 1'b1;
			rx_data     <= data_q[0];
			void'(due_q.pop_front());
			void'(data_q.pop_front());
		end else begin
			rx_rd_valid <= 1'b0;
		end
		if (!batch_active) begin
			if (load_started && exp_rd.size() > 0)
				report_problem("batch ended with reads still missing");
			hand_reads   = 0;
			load_started = 1'b0;
			exp_rd.delete();
		end
		if (tx_rd_valid) begin
			// responses stay in order, 1 to 4 cycles late
			due = cycles + 1 + int'(rng[1:0]);
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			due_q.push_back(due);
			if (tx_rd_addr == hand_ptr[57:0]) begin
				hs_line = '0;
				hs_line[`BATCH_SIZE_LSB +: 10] = 10'(table_rows[rr].batch_size);
				// the other parity's flag is always set as a decoy
				if (rr % 2 == 0)
					hs_line[`FLAG_BIT_ODD] = 1'b1;
				else
					hs_line[`FLAG_BIT_EVEN] = 1'b1;
				if ((hand_reads >> 1) >= table_rows[rr].polls) begin
					if (rr % 2 == 0)
						hs_line[`FLAG_BIT_EVEN] = 1'b1;
					else
						hs_line[`FLAG_BIT_ODD] = 1'b1;
				end
				data_q.push_back(hs_line);
				if (load_started)
					report_problem("poll read after loading began");
				hand_reads++;
			end else begin
				data_q.push_back(mem_line(tx_rd_addr));
				if (!load_started) begin
					load_started = 1'b1;
					if (hand_reads != 2 * (table_rows[rr].polls + 1))
						report_problem("loading did not start right after the flagged poll");
					for (int i = 0; i < table_rows[rr].batch_size * 4; i++) begin
						exp_rd.push_back(input_base[57:0] + 58'(i));
						exp_rd.push_back(input_base[57:0] + 58'(i));
					end
					for (int j = 0; j < table_rows[rr].lookups; j++) begin
						exp_rd.push_back(src_ptr[57:0] + 58'(lookup_k_of(rr, j) >> 4));
						exp_rd.push_back(src_ptr[57:0] + 58'(lookup_l_of(rr, j) >> 4));
					end
				end
				if (exp_rd.size() == 0) begin
					report_problem("unexpected extra read request");
				end else begin
					if (tx_rd_addr !== exp_rd[0])
						report_mismatch("tx_rd_addr", tx_rd_addr, exp_rd[0]);
					void'(exp_rd.pop_front());
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// engine model
	// ------------------------------------------------------------------------
	int phase;
	int load_cnt;
	int lk_idx;
	int lr_idx;
	int res_idx;
	int er;

	always @(posedge CLK_200M) begin
		er = safe_row(row);
		if (!batch_active) begin
			phase    = 0;
			load_cnt = 0;
			lk_idx   = 0;
			lr_idx   = 0;
			res_idx  = 0;
			read_load_done <= 1'b0;
			lookup_valid   <= 1'b0;
			output_request <= 1'b0;
			result_valid   <= 1'b0;
			result_finish  <= 1'b0;
		end else begin
			if (load_valid) begin
				if (load_data !== mem_line(input_base[57:0] + 58'(load_cnt)))
					report_mismatch("load_data", load_data,
						mem_line(input_base[57:0] + 58'(load_cnt)));
				load_cnt++;
				if (load_cnt > table_rows[er].batch_size * 4)
					report_problem("more loaded lines than the batch holds");
			end
			if (lookup_ready) begin
				if (lookup_line_k !== mem_line(src_ptr[57:0] + 58'(lookup_k_of(er, lr_idx) >> 4)))
					report_mismatch("lookup_line_k", lookup_line_k,
						mem_line(src_ptr[57:0] + 58'(lookup_k_of(er, lr_idx) >> 4)));
				if (lookup_line_l !== mem_line(src_ptr[57:0] + 58'(lookup_l_of(er, lr_idx) >> 4)))
					report_mismatch("lookup_line_l", lookup_line_l,
						mem_line(src_ptr[57:0] + 58'(lookup_l_of(er, lr_idx) >> 4)));
				lr_idx++;
			end
			case (phase)
				0: begin
					if (load_cnt == table_rows[er].batch_size * 4) begin
						read_load_done <= 1'b1;
						phase = 1;
					end
				end
				// controller enters run on this edge
				1: begin
					if (read_load_done && !engine_stall) begin
						if (table_rows[er].lookups > 0) begin
							lookup_valid <= 1'b1;
							lookup_k     <= lookup_k_of(er, 0);
							lookup_l     <= lookup_l_of(er, 0);
							phase = 2;
						end else begin
							phase = 3;
						end
					end
				end
				2: begin
					if (lookup_valid && !engine_stall) begin
						lk_idx++;
						if (lk_idx < table_rows[er].lookups) begin
							lookup_k <= lookup_k_of(er, lk_idx);
							lookup_l <= lookup_l_of(er, lk_idx);
						end else begin
							lookup_valid <= 1'b0;
							phase = 3;
						end
					end
				end
				3: begin
					if (lr_idx == table_rows[er].lookups) begin
						output_request <= 1'b1;
						phase = 4;
					end
				end
				4: begin
					if (output_permit) begin
						output_request <= 1'b0;
						read_load_done <= 1'b0;
						if (table_rows[er].results > 0) begin
							result_valid <= 1'b1;
							result_data  <= result_line(er, 0);
							phase = 5;
						end else begin
							result_finish <= 1'b1;
							phase = 6;
						end
					end
				end
				5: begin
					if (result_valid && !engine_stall) begin
						res_idx++;
						if (res_idx < table_rows[er].results) begin
							result_data <= result_line(er, res_idx);
						end else begin
							result_valid  <= 1'b0;
							result_finish <= 1'b1;
							phase = 6;
						end
					end
				end
				6: begin
					if (result_finish && !engine_stall) begin
						result_finish <= 1'b0;
						phase = 7;
					end
				end
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// write order check
	// ------------------------------------------------------------------------
	int                 wr_idx = 0;
	int                 nres;
	host_pkg::cl_addr_t exp_addr;
	host_pkg::cl_data_t exp_data;
	logic               exp_fence;

	always @(posedge CLK_200M) begin
		if (tx_fence_valid && !tx_wr_valid)
			report_problem("fence flagged without a write");
		if (tx_wr_valid) begin
			nres      = table_rows[safe_row(row)].results;
			exp_addr  = '0;
			exp_data  = '0;
			if (wr_idx < nres) begin
				exp_addr = dst_ptr[57:0] + 58'(wr_idx);
				exp_data = result_line(row, wr_idx);
			end else if (wr_idx == nres + 1) begin
				exp_addr = hand_ptr[57:0];
				exp_data[511:480] = 32'd`DONE_CODE;
			end else begin
				exp_data[511] = 1'b1;
			end
			// fence flag follows the top data bit of every write
			exp_fence = exp_data[`FENCE_BIT];
			if (tx_wr_addr !== exp_addr)
				report_mismatch("tx_wr_addr", tx_wr_addr, exp_addr);
			if (tx_data !== exp_data)
				report_mismatch("tx_data", tx_data, exp_data);
			if (tx_fence_valid !== exp_fence)
				report_mismatch("tx_fence_valid", tx_fence_valid, exp_fence);
			if (wr_idx == nres + 2) begin
				wr_idx = 0;
				row <= row + 1;
			end else begin
				wr_idx++;
			end
		end
	end

	// run limit
	always @(posedge CLK_200M) begin
		if (cycles > limit) begin
			report_problem("timeout, the batches did not complete");
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int units;
		units = 0;
		for (int r = 0; r < n_rows; r++) begin
			units += 2 * (table_rows[r].polls + 1) + 8 * table_rows[r].batch_size;
			units += 2 * table_rows[r].lookups + table_rows[r].results + 4;
		end
		limit = 20 * units + 200;
		reset_n    = 1'b0;
		core_start = 1'b0;
		repeat (2) @(posedge CLK_200M);
		reset_n <= 1'b1;

		// idle outputs with core_start low
		repeat (4) begin
			@(posedge CLK_200M);
			if (tx_rd_valid !== 1'b0)
				report_mismatch("tx_rd_valid", tx_rd_valid, 0);
			if (tx_wr_valid !== 1'b0)
				report_mismatch("tx_wr_valid", tx_wr_valid, 0);
			if (tx_fence_valid !== 1'b0)
				report_mismatch("tx_fence_valid", tx_fence_valid, 0);
			if (load_valid !== 1'b0)
				report_mismatch("load_valid", load_valid, 0);
			if (lookup_ready !== 1'b0)
				report_mismatch("lookup_ready", lookup_ready, 0);
			if (output_permit !== 1'b0)
				report_mismatch("output_permit", output_permit, 0);
			if (batch_active !== 1'b0)
				report_mismatch("batch_active", batch_active, 0);
		end

		core_start <= 1'b1;
		for (int r = 0; r < n_rows; r++) begin
			while (row <= r)
				@(posedge CLK_200M);
			$display("batch %0d done at %0t ns", r, $time);
		end
		core_start <= 1'b0;
		@(posedge CLK_200M);

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog/afu_core.sv
`timescale 1ns/100ps

module afu_core (
	input  logic                    CLK_200M,
	input  logic                    reset_n,
	input  logic                    core_start,
	input  host_pkg::host_ptr_t     src_ptr,
	input  host_pkg::host_ptr_t     dst_ptr,
	input  host_pkg::host_ptr_t     hand_ptr,
	input  host_pkg::host_ptr_t     input_base,
	// host read request
	input  logic                    rd_almostfull,
	output logic                    tx_rd_valid,
	output host_pkg::cl_addr_t      tx_rd_addr,
	// host write request
	input  logic                    wr_almostfull,
	output logic                    tx_wr_valid,
	output host_pkg::cl_addr_t      tx_wr_addr,
	output host_pkg::cl_data_t      tx_data,
	output logic                    tx_fence_valid,
	// host read response, in request order
	input  logic                    rx_rd_valid,
	input  host_pkg::cl_data_t      rx_data,
	// alignment engine, which holds lookups and results while engine_stall
	output logic                    engine_stall,
	output logic                    batch_active,
	output logic                    load_valid,
	output host_pkg::cl_data_t      load_data,
	input  logic                    read_load_done,
	input  logic                    lookup_valid,
	input  batch_pkg::engine_addr_t lookup_k,
	input  batch_pkg::engine_addr_t lookup_l,
	output logic                    lookup_ready,
	output host_pkg::cl_data_t      lookup_line_k,
	output host_pkg::cl_data_t      lookup_line_l,
	input  logic                    output_request,
	output logic                    output_permit,
	input  logic                    result_valid,
	input  host_pkg::cl_data_t      result_data,
	input  logic                    result_finish
);

	// controller to request queue
	logic               pair_valid;
	host_pkg::cl_addr_t addr_k;
	host_pkg::cl_addr_t addr_l;

	// pairer to controller
	logic               pair_ready;

	host_request_queue request_queue_i (
		.CLK_200M      (CLK_200M),
		.reset_n       (reset_n),
		.pair_valid    (pair_valid),
		.addr_k        (addr_k),
		.addr_l        (addr_l),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.hold          (engine_stall),
		.tx_rd_valid   (tx_rd_valid),
		.tx_rd_addr    (tx_rd_addr)
	);

	response_pairer pairer_i (
		.CLK_200M   (CLK_200M),
		.reset_n    (reset_n),
		.rx_rd_valid(rx_rd_valid),
		.rx_data    (rx_data),
		.pair_ready (pair_ready),
		.line_k     (lookup_line_k),
		.line_l     (lookup_line_l)
	);

	batch_controller controller_i (
		.CLK_200M       (CLK_200M),
		.reset_n        (reset_n),
		.core_start     (core_start),
		.src_ptr        (src_ptr),
		.dst_ptr        (dst_ptr),
		.hand_ptr       (hand_ptr),
		.input_base     (input_base),
		.hold           (engine_stall),
		.pair_ready     (pair_ready),
		.line_k         (lookup_line_k),
		.line_l         (lookup_line_l),
		.pair_valid     (pair_valid),
		.addr_k         (addr_k),
		.addr_l         (addr_l),
		.tx_wr_valid    (tx_wr_valid),
		.tx_wr_addr     (tx_wr_addr),
		.tx_data        (tx_data),
		.tx_fence_valid (tx_fence_valid),
		.batch_active   (batch_active),
		.load_valid     (load_valid),
		.load_data      (load_data),
		.read_load_done (read_load_done),
		.lookup_valid   (lookup_valid),
		.lookup_k       (lookup_k),
		.lookup_l       (lookup_l),
		.lookup_ready   (lookup_ready),
		.output_request (output_request),
		.output_permit  (output_permit),
		.result_valid   (result_valid),
		.result_data    (result_data),
		.result_finish  (result_finish)
	);

endmodule

// File: verilog/afu_params.svh
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// host memory bus
`define CL_ADDR_WIDTH        58
`define CL_WIDTH             512
`define HOST_PTR_WIDTH       64

// batch and engine sizing
`define READ_NUM_WIDTH       9
`define ENGINE_ADDR_WIDTH    32
`define ENGINE_ADDR_SHIFT    4
`define LINES_PER_READ_SHIFT 2
`define REQ_QUEUE_DEPTH_LOG2 2

// handshake line layout
`define FLAG_BIT_EVEN        480
`define FLAG_BIT_ODD         482
`define BATCH_SIZE_LSB       448
`define DONE_FIELD_LSB       480
`define DONE_CODE            16
`define FENCE_BIT            511

`endif

// File: verilog/batch_controller.sv
`timescale 1ns/100ps
`include "afu_params.svh"

module batch_controller (
	input  logic                   CLK_200M,
	input  logic                   reset_n,
	input  logic                   core_start,
	input  host_pkg::host_ptr_t    src_ptr,
	input  host_pkg::host_ptr_t    dst_ptr,
	input  host_pkg::host_ptr_t    hand_ptr,
	input  host_pkg::host_ptr_t    input_base,
	input  logic                   hold,
	// paired responses
	input  logic                   pair_ready,
	input  host_pkg::cl_data_t     line_k,
	input  host_pkg::cl_data_t     line_l,
	// paired requests
	output logic                   pair_valid,
	output host_pkg::cl_addr_t     addr_k,
	output host_pkg::cl_addr_t     addr_l,
	// host write port
	output logic                   tx_wr_valid,
	output host_pkg::cl_addr_t     tx_wr_addr,
	output host_pkg::cl_data_t     tx_data,
	output logic                   tx_fence_valid,
	// engine side
	output logic                   batch_active,
	output logic                   load_valid,
	output host_pkg::cl_data_t     load_data,
	input  logic                   read_load_done,
	input  logic                   lookup_valid,
	input  batch_pkg::engine_addr_t lookup_k,
	input  batch_pkg::engine_addr_t lookup_l,
	output logic                   lookup_ready,
	input  logic                   output_request,
	output logic                   output_permit,
	input  logic                   result_valid,
	input  host_pkg::cl_data_t     result_data,
	input  logic                   result_finish
);

	localparam host_pkg::cl_data_t fence_line = host_pkg::cl_data_t'(1) << `FENCE_BIT;
	localparam host_pkg::cl_data_t done_line =
		host_pkg::cl_data_t'(32'(`DONE_CODE)) << `DONE_FIELD_LSB;

	batch_pkg::batch_state_t state;
	batch_pkg::batch_state_t state_d;

	logic                   parity;
	logic                   flag_set;
	batch_pkg::batch_size_t batch_size;
	batch_pkg::load_ptr_t   issue_ptr;
	batch_pkg::load_ptr_t   lines_total;
	host_pkg::cl_addr_t     out_addr;

	host_pkg::cl_addr_t     load_addr;
	host_pkg::cl_addr_t     lookup_addr_k;
	host_pkg::cl_addr_t     lookup_addr_l;
	host_pkg::cl_addr_t     result_addr;

	logic                   wr_go;
	host_pkg::cl_addr_t     wr_addr_d;
	host_pkg::cl_data_t     wr_data_d;

	// flag bit alternates between batches
	assign flag_set = parity ? line_l[`FLAG_BIT_ODD] : line_l[`FLAG_BIT_EVEN];

	assign lines_total = batch_pkg::load_ptr_t'(batch_size) << `LINES_PER_READ_SHIFT;

	assign load_addr = input_base[`CL_ADDR_WIDTH-1:0] + host_pkg::cl_addr_t'(issue_ptr);
	assign lookup_addr_k = src_ptr[`CL_ADDR_WIDTH-1:0] +
		host_pkg::cl_addr_t'(lookup_k[`ENGINE_ADDR_WIDTH-1:`ENGINE_ADDR_SHIFT]);
	assign lookup_addr_l = src_ptr[`CL_ADDR_WIDTH-1:0] +
		host_pkg::cl_addr_t'(lookup_l[`ENGINE_ADDR_WIDTH-1:`ENGINE_ADDR_SHIFT]);
	assign result_addr = dst_ptr[`CL_ADDR_WIDTH-1:0] + out_addr;

	// engine reads the pairer lines directly during run
	assign lookup_ready = pair_ready && (state == batch_pkg::st_run);

	// -------------------------------------------------------------------------
	// next state, pair issue and write decision
	// -------------------------------------------------------------------------
	always_comb begin
		state_d    = state;
		pair_valid = 1'b0;
		addr_k     = '0;
		addr_l     = '0;
		wr_go      = 1'b0;
		wr_addr_d  = '0;
		wr_data_d  = '0;
		case (state)
			batch_pkg::st_idle: begin
				if (core_start) begin
					state_d = batch_pkg::st_poll_issue;
				end
			end
			batch_pkg::st_poll_issue: begin
				if (!hold) begin
					pair_valid = 1'b1;
					addr_k     = hand_ptr[`CL_ADDR_WIDTH-1:0];
					addr_l     = hand_ptr[`CL_ADDR_WIDTH-1:0];
					state_d    = batch_pkg::st_poll_wait;
				end
			end
			// response cannot be stalled, so hold is not looked at here
			batch_pkg::st_poll_wait: begin
				if (pair_ready) begin
					state_d = flag_set ? batch_pkg::st_load : batch_pkg::st_poll_issue;
				end
			end
			batch_pkg::st_load: begin
				if (!hold) begin
					// same line twice keeps the k/l pairing intact
					if (issue_ptr < lines_total) begin
						pair_valid = 1'b1;
						addr_k     = load_addr;
						addr_l     = load_addr;
					end
					if (read_load_done) begin
						state_d = batch_pkg::st_run;
					end
				end
			end
			batch_pkg::st_run: begin
				if (!hold) begin
					if (output_request) begin
						state_d = batch_pkg::st_output;
					end else if (lookup_valid) begin
						pair_valid = 1'b1;
						addr_k     = lookup_addr_k;
						addr_l     = lookup_addr_l;
					end
				end
			end
			batch_pkg::st_output: begin
				if (!hold) begin
					if (result_finish) begin
						wr_go     = 1'b1;
						wr_data_d = fence_line;
						state_d   = batch_pkg::st_final_done;
					end else if (result_valid) begin
						wr_go     = 1'b1;
						wr_addr_d = result_addr;
						wr_data_d = result_data;
					end
				end
			end
			batch_pkg::st_final_done: begin
				if (!hold) begin
					wr_go     = 1'b1;
					wr_addr_d = hand_ptr[`CL_ADDR_WIDTH-1:0];
					wr_data_d = done_line;
					state_d   = batch_pkg::st_final_fence;
				end
			end
			batch_pkg::st_final_fence: begin
				if (!hold) begin
					wr_go     = 1'b1;
					wr_data_d = fence_line;
					state_d   = batch_pkg::st_idle;
				end
			end
			default: begin
				state_d = batch_pkg::st_idle;
			end
		endcase
	end

	// -------------------------------------------------------------------------
	// control registers
	// -------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state          <= batch_pkg::st_idle;
			parity         <= 1'b0;
			issue_ptr      <= '0;
			out_addr       <= '0;
			batch_active   <= 1'b0;
			output_permit  <= 1'b0;
			load_valid     <= 1'b0;
			tx_wr_valid    <= 1'b0;
			tx_fence_valid <= 1'b0;
		end else begin
			state          <= state_d;
			batch_active   <= (state_d != batch_pkg::st_idle);
			output_permit  <= (state_d inside {batch_pkg::st_output,
				batch_pkg::st_final_done, batch_pkg::st_final_fence});
			load_valid     <= pair_ready && (state == batch_pkg::st_load);
			tx_wr_valid    <= wr_go;
			tx_fence_valid <= wr_go && wr_data_d[`FENCE_BIT];

			// flag seen, new batch starts
			if (state == batch_pkg::st_poll_wait && pair_ready && flag_set) begin
				parity    <= ~parity;
				issue_ptr <= '0;
			end else if (pair_valid && state == batch_pkg::st_load) begin
				issue_ptr <= issue_ptr + 1'b1;
			end

			if (state == batch_pkg::st_idle) begin
				out_addr <= '0;
			end else if (wr_go && state_d == batch_pkg::st_output) begin
				out_addr <= out_addr + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge CLK_200M) begin
		if (state == batch_pkg::st_poll_wait && pair_ready && flag_set) begin
			batch_size <= line_l[`BATCH_SIZE_LSB +: $bits(batch_pkg::batch_size_t)];
		end
		if (pair_ready) begin
			load_data <= line_k;
		end
		if (wr_go) begin
			tx_wr_addr <= wr_addr_d;
			tx_data    <= wr_data_d;
		end
	end

	// hold blocks a pair now and the registered write one cycle later
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		hold |-> !pair_valid ##1 !tx_wr_valid);

endmodule

// File: verilog/batch_pkg.sv
`include "afu_params.svh"

// ---------------------------------------------------------------------------
// batch control and engine side types
// ---------------------------------------------------------------------------
package batch_pkg;

	// read count, one bit wider so a full batch fits
	typedef logic [`READ_NUM_WIDTH:0] batch_size_t;

	// index of a read line, batch size times lines per read
	typedef logic [`READ_NUM_WIDTH+`LINES_PER_READ_SHIFT:0] load_ptr_t;

	// engine lookup address, low bits are within a line
	typedef logic [`ENGINE_ADDR_WIDTH-1:0] engine_addr_t;

	typedef enum logic [2:0] {
		st_idle,
		st_poll_issue,
		st_poll_wait,
		st_load,
		st_run,
		st_output,
		st_final_done,
		st_final_fence
	} batch_state_t;

endpackage

// File: verilog/host_pkg.sv
`include "afu_params.svh"

// ---------------------------------------------------------------------------
// host memory bus types
// ---------------------------------------------------------------------------
package host_pkg;

	// cache-line address, byte offset already dropped
	typedef logic [`CL_ADDR_WIDTH-1:0] cl_addr_t;

	// one full cache line
	typedef logic [`CL_WIDTH-1:0] cl_data_t;

	// pointers as handed over by the host
	typedef logic [`HOST_PTR_WIDTH-1:0] host_ptr_t;

endpackage

// File: verilog/host_request_queue.sv
`timescale 1ns/100ps
`include "afu_params.svh"

module host_request_queue (
	input  logic               CLK_200M,
	input  logic               reset_n,
	input  logic               pair_valid,
	input  host_pkg::cl_addr_t addr_k,
	input  host_pkg::cl_addr_t addr_l,
	input  logic               rd_almostfull,
	input  logic               wr_almostfull,
	output logic               hold,
	output logic               tx_rd_valid,
	output host_pkg::cl_addr_t tx_rd_addr
);

	localparam int depth = 1 << `REQ_QUEUE_DEPTH_LOG2;

	// one extra bit tells full from empty
	typedef logic [`REQ_QUEUE_DEPTH_LOG2:0] qptr_t;

	host_pkg::cl_addr_t k_mem [depth];
	host_pkg::cl_addr_t l_mem [depth];

	qptr_t wr_ptr;
	qptr_t rd_ptr;
	qptr_t count;
	logic  empty;
	logic  full;
	logic  half;
	logic  af_q;

	assign count = wr_ptr - rd_ptr;
	assign empty = (count == '0);
	assign full  = (count == qptr_t'(depth));

	// one slot of slack covers the pair already decided upstream
	assign hold = af_q | (count >= qptr_t'(depth - 1));

	// -------------------------------------------------------------------------
	// push side
	// -------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			af_q   <= 1'b0;
		end else begin
			af_q <= rd_almostfull | wr_almostfull;
			if (pair_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (pair_valid) begin
			k_mem[wr_ptr[`REQ_QUEUE_DEPTH_LOG2-1:0]] <= addr_k;
			l_mem[wr_ptr[`REQ_QUEUE_DEPTH_LOG2-1:0]] <= addr_l;
		end
	end

	// -------------------------------------------------------------------------
	// read side sends k then l of the head pair
	// -------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			rd_ptr      <= '0;
			half        <= 1'b0;
			tx_rd_valid <= 1'b0;
		end else begin
			tx_rd_valid <= !empty;
			if (!empty) begin
				half <= ~half;
				// head pair is done once its l read is out
				if (half) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (!empty) begin
			tx_rd_addr <= half ? l_mem[rd_ptr[`REQ_QUEUE_DEPTH_LOG2-1:0]]
			                   : k_mem[rd_ptr[`REQ_QUEUE_DEPTH_LOG2-1:0]];
		end
	end

	// upstream respects hold, so the queue never overflows
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		pair_valid |-> !full);

	// queue never drains with a pair half sent
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		empty |-> !half);

endmodule

// File: verilog/response_pairer.sv
`timescale 1ns/100ps

module response_pairer (
	input  logic               CLK_200M,
	input  logic               reset_n,
	input  logic               rx_rd_valid,
	input  host_pkg::cl_data_t rx_data,
	output logic               pair_ready,
	output host_pkg::cl_data_t line_k,
	output host_pkg::cl_data_t line_l
);

	// 0 while waiting for k, 1 while waiting for l
	logic beat_odd;

	// -------------------------------------------------------------------------
	// beat parity and pair strobe
	// -------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			beat_odd   <= 1'b0;
			pair_ready <= 1'b0;
		end else begin
			// strobe in the cycle after the l beat
			pair_ready <= rx_rd_valid & beat_odd;
			if (rx_rd_valid) begin
				beat_odd <= ~beat_odd;
			end
		end
	end

	// -------------------------------------------------------------------------
	// line capture
	// -------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (rx_rd_valid && !beat_odd) begin
			line_k <= rx_data;
		end
	end

	// k stays put until the next pair starts arriving
	always_ff @(posedge CLK_200M) begin
		if (rx_rd_valid && beat_odd) begin
			line_l <= rx_data;
		end
	end

endmodule
